// ==== Bender.yml ====
package:
  name: scope_core

sources:
  - verilog/scope_pkg.sv
  - verilog/cmd_receiver.sv
  - verilog/acq_trigger.sv
  - verilog/sample_ram.sv
  - verilog/cmd_processor.sv
  - verilog/resp_stream.sv
  - verilog/scope_top.sv
  - target: test
    files:
      - verification/tb_clkgen.sv
      - verification/tb_scope_top.sv

// ==== scope_top.f ====
verilog/scope_pkg.sv
verilog/cmd_receiver.sv
verilog/acq_trigger.sv
verilog/sample_ram.sv
verilog/cmd_processor.sv
verilog/resp_stream.sv
verilog/scope_top.sv
verification/tb_clkgen.sv
verification/tb_scope_top.sv

// ==== verification/tb_clkgen.sv ====
// tb_clkgen
// free-running testbench clock
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter real PERIOD = 8.0 // ns
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk; // 50% duty
	end

endmodule

`default_nettype wire

// ==== verification/tb_scope_top.sv ====
// tb_scope_top
// directed tests for the acquisition core, byte commands in, reply beats out
`timescale 1ns/1ps
`default_nettype none

module tb_scope_top import scope_pkg::*; ();

	localparam int TIMEOUT = 200; // cycles per wait

	logic                       clk;
	logic                       rstn;
	logic                       i_tvalid;
	logic [7:0]                 i_tdata;
	logic                       o_tready;
	logic                       o_tvalid;
	logic [31:0]                o_tdata;
	logic [3:0]                 o_tkeep;
	logic                       o_tlast;
	logic                       i_tready;
	logic signed [SAMPLE_W-1:0] i_sample;
	logic                       i_sample_valid;

	int          seed = 85;    // back-pressure pattern
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	bit          timed_out;
	string       cur_test;
	logic [11:0] sample_cnt;   // ramp source
	bit          force_on;     // hold a fixed level instead of the ramp
	logic [11:0] force_level;
	logic [31:0] rx_data[$];   // beats of the last reply
	logic [3:0]  rx_keep[$];
	logic        rx_last[$];

	tb_clkgen #(.PERIOD(8.0)) u_clkgen (.clk(clk));

	scope_top #(.ADDR_W(8)) i_scope_top (
		.clk            (clk),
		.rstn           (rstn),
		.i_tvalid       (i_tvalid),
		.i_tdata        (i_tdata),
		.o_tready       (o_tready),
		.o_tvalid       (o_tvalid),
		.o_tdata        (o_tdata),
		.o_tkeep        (o_tkeep),
		.o_tlast        (o_tlast),
		.i_tready       (i_tready),
		.i_sample       (i_sample),
		.i_sample_valid (i_sample_valid)
	);

	// ----------------------------------------
	// adc sample source
	// ----------------------------------------
	initial begin
		sample_cnt     = '0;
		force_on       = 1'b0;
		force_level    = '0;
		i_sample       = '0;
		i_sample_valid = 1'b0;
		@(posedge rstn);
		forever begin
			@(negedge clk);
			i_sample_valid = 1'b1; // one sample every cycle
			i_sample       = force_on ? force_level : sample_cnt;
			sample_cnt     = sample_cnt + 12'd1;
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	// byte 0 is the opcode, b3 unused here
	function automatic logic [63:0] pack_cmd(input logic [7:0] op, input logic [7:0] b1,
		input logic [7:0] b2, input logic [7:0] b4, input logic [7:0] b5,
		input logic [7:0] b6, input logic [7:0] b7);
		return {b7, b6, b5, b4, 8'h00, b2, b1, op};
	endfunction

	// threshold from center and hysteresis, scaled to adc counts
	function automatic logic [11:0] threshold(input int center, input int hyst, input bit high);
		int          v;
		logic [11:0] r;
		v = high ? (center + hyst - 128) : (center - hyst - 128);
		r = v * 16 + 8; // truncated to 12 bits
		return r;
	endfunction

	task automatic begin_test(input string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		errors += test_errors;
		if (test_errors == 0) begin
			$display("test %s: passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", cur_test, test_errors);
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAILED %s, %s: expected %h, actual %h", cur_test, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string msg);
		assert (cond) else begin
			$display("test %s: %s", cur_test, msg);
			test_errors++;
		end
	endtask

	task automatic note_timeout(input string msg);
		$display("timeout in test %s: %s", cur_test, msg);
		timed_out = 1'b1;
		test_errors++;
	endtask

	task automatic send_cmd(input logic [63:0] cmd);
		int k;
		int t;
		for (k = 0; k < 8; k++) begin
			@(negedge clk);
			i_tvalid = 1'b1;
			i_tdata  = cmd[8*k +: 8];
			t = 0;
			while (!o_tready && t < TIMEOUT) begin // receiver still busy
				@(negedge clk);
				t++;
			end
			if (!o_tready) begin
				i_tvalid = 1'b0;
				note_timeout("command input never became ready");
				return;
			end
			@(posedge clk); // byte taken here
		end
		@(negedge clk);
		i_tvalid = 1'b0;
	endtask

	// collects beats up to the one marked last
	task automatic get_reply(input bit backpressure);
		int t;
		bit done;
		rx_data.delete();
		rx_keep.delete();
		rx_last.delete();
		t    = 0;
		done = 1'b0;
		while (!done && t < TIMEOUT) begin
			@(negedge clk);
			i_tready = backpressure ? (($random(seed) & 3) != 0) : 1'b1;
			if (o_tvalid && i_tready) begin // taken at the next rising edge
				rx_data.push_back(o_tdata);
				rx_keep.push_back(o_tkeep);
				rx_last.push_back(o_tlast);
				done = o_tlast;
				t    = 0;
			end else begin
				t++;
			end
		end
		@(negedge clk);
		i_tready = 1'b1;
		if (!done) note_timeout("reply never ended with a last beat");
	endtask

	task automatic query_arm(input logic [7:0] trig, output logic [31:0] status);
		send_cmd(pack_cmd(CMD_ARM, trig, 8'd0, 8'd16, 8'd0, 8'd0, 8'd0)); // 16 post samples
		get_reply(1'b0);
		status = (rx_data.size() > 0) ? rx_data[0] : 32'hxxxx_xxxx;
	endtask

	task automatic wait_event(input logic [7:0] trig, output logic [31:0] status);
		int n;
		n = 0;
		query_arm(trig, status);
		while (status[15:0] !== 16'hffff && n < 40 && !timed_out) begin
			query_arm(trig, status);
			n++;
		end
		if (status[15:0] !== 16'hffff && !timed_out) note_timeout("event never became ready");
	endtask

	// a short read hands the held event back to the trigger
	task automatic release_event();
		send_cmd(pack_cmd(CMD_READ, 8'd0, 8'd0, 8'd4, 8'd0, 8'd0, 8'd0));
		get_reply(1'b0);
		check_value("release beats", 32'd1, rx_data.size());
	endtask

	// ramp samples sit in consecutive slots, so pairs count up by one
	task automatic check_pairs();
		logic [11:0] lo;
		logic [11:0] hi;
		logic [11:0] exp_s;
		logic [11:0] prev_hi;
		int          i;
		prev_hi = '0;
		for (i = 0; i < rx_data.size(); i++) begin
			lo = rx_data[i][11:0];
			hi = rx_data[i][27:16];
			check_value("zero nibbles", 32'd0, {rx_data[i][31:28], rx_data[i][15:12]});
			exp_s = lo + 12'd1;
			check_value("later sample", exp_s, hi);
			if (i > 0) begin
				exp_s = prev_hi + 12'd1;
				check_value("word continuity", exp_s, lo);
			end
			prev_hi = hi;
		end
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic test_reset_version();
		begin_test("reset and version");
		check_value("o_tvalid after reset", 32'd0, o_tvalid);
		check_value("o_tready after reset", 32'd1, o_tready);
		send_cmd(pack_cmd(CMD_INFO, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0));
		get_reply(1'b0);
		check_value("beat count", 32'd1, rx_data.size());
		if (rx_data.size() == 1) begin
			check_value("version", 32'd17, rx_data[0]);
			check_value("keep", 32'hf, rx_keep[0]);
			check_value("last", 32'd1, rx_last[0]);
		end
		end_test();
	endtask

	task automatic test_immediate();
		logic [31:0] status;
		begin_test("immediate trigger");
		query_arm(TRIG_NONE, status);
		check_value("events before arm", 32'd0, status[31:16]);
		wait_event(TRIG_NONE, status);
		check_value("event count", 32'd1, status[31:16]);
		end_test();
	endtask

	task automatic test_readout();
		logic [31:0] status;
		int          i;
		begin_test("readout content");
		send_cmd(pack_cmd(CMD_READ, 8'd0, 8'd0, 8'd16, 8'd0, 8'd0, 8'd0));
		get_reply(1'b0);
		check_value("beat count", 32'd4, rx_data.size());
		for (i = 0; i < rx_data.size(); i++) begin
			check_value("keep", 32'hf, rx_keep[i]);
			check_value("last", (i == 3), rx_last[i]);
		end
		check_pairs();
		query_arm(TRIG_NONE, status); // buffer freed, arm must take
		check_value("status at rearm", 32'h0001_0000, status);
		wait_event(TRIG_NONE, status);
		check_value("event count", 32'd2, status[31:16]);
		end_test();
	endtask

	task automatic test_rising();
		logic [31:0] status;
		logic [11:0] lower;
		logic [11:0] upper;
		begin_test("rising threshold trigger");
		release_event();
		lower = threshold(128, 16, 1'b0);
		upper = threshold(128, 16, 1'b1);
		@(posedge clk);
		force_level = 12'd0; // between both thresholds
		force_on    = 1'b1;
		send_cmd(pack_cmd(CMD_TRIG_SET, 8'd128, 8'd16, 8'd4, 8'd2, 8'd0, 8'd0));
		get_reply(1'b0);
		if (rx_data.size() > 0) check_value("trigger set reply", 32'd8, rx_data[0]);
		query_arm(TRIG_RISE, status);
		query_arm(TRIG_RISE, status);
		check_value("no event at level 0", 32'd0, status[15:0]);
		@(posedge clk);
		force_level = upper + 12'd16;
		repeat (4) @(posedge clk);
		force_level = lower - 12'd16;
		repeat (3) @(posedge clk); // tot 2 needs three samples
		force_on = 1'b0;
		wait_event(TRIG_RISE, status);
		check_value("event count", 32'd3, status[31:16]);
		end_test();
	endtask

	task automatic test_backpressure();
		logic [31:0] status;
		begin_test("back-pressure and partial word");
		release_event();
		query_arm(TRIG_NONE, status);
		check_value("arm accepted", 32'd0, status[15:0]);
		wait_event(TRIG_NONE, status);
		check_value("event count", 32'd4, status[31:16]);
		send_cmd(pack_cmd(CMD_READ, 8'd0, 8'd0, 8'd10, 8'd0, 8'd0, 8'd0));
		get_reply(1'b1);
		check_value("beat count", 32'd3, rx_data.size());
		if (rx_data.size() == 3) begin
			check_value("keep 0", 32'hf, rx_keep[0]);
			check_value("keep 1", 32'hf, rx_keep[1]);
			check_value("keep 2", 32'h3, rx_keep[2]); // 2 bytes left
			check_value("last", 32'b100, {rx_last[2], rx_last[1], rx_last[0]});
		end
		check_pairs();
		end_test();
	endtask

	task automatic test_unknown();
		bit quiet;
		begin_test("unknown opcode");
		send_cmd(pack_cmd(8'd5, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0));
		quiet = 1'b1;
		repeat (50) begin
			@(negedge clk);
			if (o_tvalid) quiet = 1'b0;
		end
		check_true(quiet, "a reply beat came for an unknown opcode");
		send_cmd(pack_cmd(CMD_INFO, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0));
		get_reply(1'b0);
		if (rx_data.size() > 0) check_value("version", 32'd17, rx_data[0]);
		end_test();
	endtask

	// ----------------------------------------
	// sequence
	// ----------------------------------------
	initial begin
		rstn         = 1'b0;
		i_tvalid     = 1'b0;
		i_tdata      = 8'd0;
		i_tready     = 1'b1;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		@(negedge clk);
		test_reset_version();
		if (!timed_out) test_immediate();
		if (!timed_out) test_readout();
		if (!timed_out) test_rising();
		if (!timed_out) test_backpressure();
		if (!timed_out) test_unknown();
		$display("tests run %0d, failed %0d, failed checks %0d", tests_run, tests_failed,
			errors);
		if (errors == 0 && !timed_out) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/acq_trigger.sv ====
// acq_trigger
// writes every valid sample into the ring buffer, runs the threshold trigger
// and keeps the event until it has been read out
`timescale 1ns/1ps
`default_nettype none

module acq_trigger import scope_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  wire                        clk,
	input  wire                        rstn,
	input  wire signed [SAMPLE_W-1:0]  i_sample,
	input  wire                        i_sample_valid,
	input  wire trig_cfg_t             i_cfg,
	input  wire                        i_arm,
	input  wire                        i_readout_done,
	output logic                       o_wr_en,
	output logic [ADDR_W-1:0]          o_wr_addr,
	output logic [SAMPLE_W-1:0]        o_wr_data,
	output logic [ADDR_W-1:0]          o_trig_addr,
	output logic [15:0]                o_event_count,
	output logic [15:0]                o_post_count
);

	acq_state_e        state_q;
	logic [ADDR_W-1:0] wr_addr_q;
	logic [7:0]        tot_cnt_q; // qualifying samples seen so far
	logic              below;     // valid sample under lower
	logic              above;     // valid sample over upper

	assign below = i_sample_valid && (i_sample < $signed(i_cfg.lower));
	assign above = i_sample_valid && (i_sample > $signed(i_cfg.upper));

	// ----------------------------------------
	// ring buffer write side
	// ----------------------------------------
	assign o_wr_en   = i_sample_valid && (state_q != ACQ_DONE); // frozen while held
	assign o_wr_addr = wr_addr_q;
	assign o_wr_data = i_sample;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) wr_addr_q <= '0;
		else if (o_wr_en) wr_addr_q <= wr_addr_q + ADDR_W'(1);
	end

	// ----------------------------------------
	// trigger FSM
	// ----------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q       <= ACQ_IDLE;
			tot_cnt_q     <= 8'd0;
			o_post_count  <= 16'd0;
			o_event_count <= 16'd0;
			o_trig_addr   <= '0;
		end else begin
			case (state_q)
			ACQ_IDLE: begin
				tot_cnt_q    <= 8'd0;
				o_post_count <= 16'd0;
				if (i_arm) begin
					case (i_cfg.trig_type)
					TRIG_FALL: state_q <= ACQ_FALL_ARM;
					TRIG_RISE: state_q <= ACQ_RISE_ARM;
					default: begin
						o_trig_addr <= wr_addr_q; // trigger right here
						state_q     <= ACQ_POST;
					end
					endcase
				end
			end
			ACQ_FALL_ARM: begin
				if (below) state_q <= ACQ_FALL_WAIT;
			end
			ACQ_FALL_WAIT: begin
				if (above) begin
					tot_cnt_q <= tot_cnt_q + 8'd1;
					if (tot_cnt_q >= i_cfg.tot) begin // count reaches tot + 1
						o_trig_addr <= wr_addr_q;
						state_q     <= ACQ_POST;
					end
				end
			end
			ACQ_RISE_ARM: begin
				if (above) state_q <= ACQ_RISE_WAIT;
			end
			ACQ_RISE_WAIT: begin
				if (below) begin
					tot_cnt_q <= tot_cnt_q + 8'd1;
					if (tot_cnt_q >= i_cfg.tot) begin
						o_trig_addr <= wr_addr_q;
						state_q     <= ACQ_POST;
					end
				end
			end
			ACQ_POST: begin
				if (o_post_count < i_cfg.length_to_take) begin
					if (i_sample_valid) o_post_count <= o_post_count + 16'd1;
				end else begin
					o_event_count <= o_event_count + 16'd1;
					o_post_count  <= '1; // host sees event ready
					state_q       <= ACQ_DONE;
				end
			end
			ACQ_DONE: begin
				if (i_readout_done) state_q <= ACQ_IDLE;
			end
			default: state_q <= ACQ_IDLE;
			endcase
		end
	end

	// a held event is never overwritten, the write pointer stays put
	assert property (@(posedge clk) disable iff (!rstn)
		(state_q == ACQ_DONE) |=> $stable(wr_addr_q));

endmodule

`default_nettype wire

// ==== verilog/cmd_processor.sv ====
// cmd_processor
// decodes commands, keeps trigger settings, and turns replies and buffer
// readout into response beats
`timescale 1ns/1ps
`default_nettype none

module cmd_processor import scope_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  wire                 clk,
	input  wire                 rstn,
	input  wire cmd_t           i_cmd,
	input  wire                 i_cmd_valid,
	output logic                o_cmd_done,
	output trig_cfg_t           o_cfg,
	output logic                o_arm,
	output logic                o_readout_done,
	input  wire  [ADDR_W-1:0]   i_trig_addr,
	input  wire  [15:0]         i_event_count,
	input  wire  [15:0]         i_post_count,
	output logic [ADDR_W-1:0]   o_rd_addr,
	input  wire  [SAMPLE_W-1:0] i_rd_data,
	output resp_beat_t          o_beat,
	output logic                o_beat_valid,
	input  wire                 i_beat_ready
);

	typedef enum logic [2:0] {
		PR_IDLE,     // waiting for a command
		PR_REPLY,    // one word answer
		PR_FETCH_LO, // earlier sample address out
		PR_FETCH_HI, // later sample address out, earlier one back
		PR_SEND      // pair on offer
	} pr_state_e;

	pr_state_e           state_q;
	logic [ADDR_W-1:0]   preoffset_q;  // samples shown before the trigger
	logic [31:0]         remain_q;     // bytes left, 4 for single words
	logic [31:0]         reply_q;
	logic [SAMPLE_W-1:0] lo_q;         // earlier sample of the pair
	logic [SAMPLE_W-1:0] thr_lo;
	logic [SAMPLE_W-1:0] thr_hi;

	function automatic logic [3:0] keep_for(input logic [31:0] r);
		logic [3:0] k;
		case (r)
			32'd0:   k = 4'b0000;
			32'd1:   k = 4'b0001;
			32'd2:   k = 4'b0011;
			32'd3:   k = 4'b0111;
			default: k = 4'b1111;
		endcase
		return k;
	endfunction

	// center b1, hysteresis b2, scaled to adc counts
	assign thr_lo = ((SAMPLE_W'(i_cmd.b1) - SAMPLE_W'(i_cmd.b2) - SAMPLE_W'(128)) << 4)
		+ SAMPLE_W'(8);
	assign thr_hi = ((SAMPLE_W'(i_cmd.b1) + SAMPLE_W'(i_cmd.b2) - SAMPLE_W'(128)) << 4)
		+ SAMPLE_W'(8);

	// ----------------------------------------
	// response beat
	// ----------------------------------------
	// in PR_SEND the read address is held, so the ram keeps the later sample
	assign o_beat_valid = (state_q == PR_REPLY) || (state_q == PR_SEND);
	assign o_beat.data  = (state_q == PR_SEND) ? {4'b0, i_rd_data, 4'b0, lo_q} : reply_q;
	assign o_beat.keep  = keep_for(remain_q);
	assign o_beat.last  = (remain_q <= 32'd4);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q        <= PR_IDLE;
			o_cfg          <= '0;
			preoffset_q    <= '0;
			remain_q       <= 32'd0;
			o_rd_addr      <= '0;
			o_arm          <= 1'b0;
			o_cmd_done     <= 1'b0;
			o_readout_done <= 1'b0;
		end else begin
			o_arm          <= 1'b0; // all three are pulses
			o_cmd_done     <= 1'b0;
			o_readout_done <= 1'b0;
			case (state_q)
			PR_IDLE: begin
				if (i_cmd_valid) begin
					remain_q <= 32'd4;
					case (i_cmd.op)
					CMD_READ: begin
						remain_q  <= {i_cmd.b7, i_cmd.b6, i_cmd.b5, i_cmd.b4};
						o_rd_addr <= i_trig_addr - preoffset_q;
						state_q   <= PR_FETCH_LO;
					end
					CMD_ARM: begin
						o_cfg.trig_type      <= trig_type_e'(i_cmd.b1);
						o_cfg.length_to_take <= {i_cmd.b5, i_cmd.b4};
						o_arm                <= (i_post_count == 16'd0); // no event pending
						state_q              <= PR_REPLY;
					end
					CMD_INFO: state_q <= PR_REPLY;
					CMD_TRIG_SET: begin
						o_cfg.lower <= thr_lo;
						o_cfg.upper <= thr_hi;
						o_cfg.tot   <= i_cmd.b5;
						preoffset_q <= ADDR_W'(i_cmd.b4);
						state_q     <= PR_REPLY;
					end
					default: o_cmd_done <= 1'b1; // unknown, dropped silently
					endcase
				end
			end
			PR_REPLY: begin
				if (i_beat_ready) begin
					o_cmd_done <= 1'b1;
					state_q    <= PR_IDLE;
				end
			end
			PR_FETCH_LO: begin
				o_rd_addr <= o_rd_addr + ADDR_W'(1);
				state_q   <= PR_FETCH_HI;
			end
			PR_FETCH_HI: state_q <= PR_SEND;
			PR_SEND: begin
				if (i_beat_ready) begin
					if (remain_q <= 32'd4) begin // that was the last word
						o_cmd_done     <= 1'b1;
						o_readout_done <= 1'b1;
						state_q        <= PR_IDLE;
					end else begin
						remain_q  <= remain_q - 32'd4;
						o_rd_addr <= o_rd_addr + ADDR_W'(1);
						state_q   <= PR_FETCH_LO;
					end
				end
			end
			default: state_q <= PR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == PR_IDLE && i_cmd_valid) begin
			case (i_cmd.op)
			CMD_ARM:      reply_q <= {i_event_count, i_post_count};
			CMD_INFO:     reply_q <= FW_VERSION;
			CMD_TRIG_SET: reply_q <= 32'd8; // echo of the opcode
			default:      reply_q <= reply_q;
			endcase
		end
		if (state_q == PR_FETCH_HI) lo_q <= i_rd_data;
	end

endmodule

`default_nettype wire

// ==== verilog/cmd_receiver.sv ====
// cmd_receiver
// gathers 8 stream bytes into one command, then blocks input until it is handled
`timescale 1ns/1ps
`default_nettype none

module cmd_receiver import scope_pkg::*; (
	input  wire        clk,
	input  wire        rstn,
	input  wire        i_tvalid,
	input  wire  [7:0] i_tdata,
	output logic       o_tready,
	input  wire        i_cmd_done,
	output cmd_t       o_cmd,
	output logic       o_cmd_valid
);

	logic [7:0][7:0] bytes_q; // byte k of the command in slot k
	logic [2:0]      cnt_q;   // next slot to fill
	logic            busy_q;  // command waiting for the processor
	logic            accept;

	assign o_tready = !busy_q;
	assign accept   = i_tvalid && o_tready;
	assign o_cmd    = cmd_t'(bytes_q);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cnt_q       <= 3'd0;
			busy_q      <= 1'b0;
			o_cmd_valid <= 1'b0;
		end else begin
			o_cmd_valid <= accept && (cnt_q == 3'd7); // one cycle after byte 7
			if (accept) begin
				cnt_q <= cnt_q + 3'd1; // wraps back to slot 0
				if (cnt_q == 3'd7) busy_q <= 1'b1;
			end else if (i_cmd_done) begin
				busy_q <= 1'b0; // ready again next cycle
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) bytes_q[cnt_q] <= i_tdata;
	end

	// the processor only finishes a command that was handed to it
	assert property (@(posedge clk) disable iff (!rstn) i_cmd_done |-> busy_q);

endmodule

`default_nettype wire

// ==== verilog/resp_stream.sv ====
// resp_stream
// one-deep holding register between the processor and the output stream
`timescale 1ns/1ps
`default_nettype none

module resp_stream import scope_pkg::*; (
	input  wire              clk,
	input  wire              rstn,
	input  wire resp_beat_t  i_beat,
	input  wire              i_beat_valid,
	output logic             o_beat_ready,
	output logic             o_tvalid,
	output logic [31:0]      o_tdata,
	output logic [3:0]       o_tkeep,
	output logic             o_tlast,
	input  wire              i_tready
);

	resp_beat_t hold_q;
	logic       full_q; // hold_q carries a beat
	logic       load;

	assign o_beat_ready = !full_q || i_tready; // empty, or draining this cycle
	assign load         = i_beat_valid && o_beat_ready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) full_q <= 1'b0;
		else if (load) full_q <= 1'b1;
		else if (i_tready) full_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load) hold_q <= i_beat;
	end

	assign o_tvalid = full_q;
	assign o_tdata  = hold_q.data;
	assign o_tkeep  = hold_q.keep;
	assign o_tlast  = hold_q.last;

	// stalled beat keeps both its valid and its payload
	assert property (@(posedge clk) disable iff (!rstn)
		(o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tkeep)
			&& $stable(o_tlast)));

endmodule

`default_nettype wire

// ==== verilog/sample_ram.sv ====
// sample_ram
// circular sample store, one write port and one registered read port
`timescale 1ns/1ps
`default_nettype none

module sample_ram import scope_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  wire                 clk,
	input  wire                 i_wr_en,
	input  wire  [ADDR_W-1:0]   i_wr_addr,
	input  wire  [SAMPLE_W-1:0] i_wr_data,
	input  wire  [ADDR_W-1:0]   i_rd_addr,
	output logic [SAMPLE_W-1:0] o_rd_data
);

	logic [SAMPLE_W-1:0] mem_q [2**ADDR_W]; // address wraps, so the buffer is a ring

	always_ff @(posedge clk) begin
		if (i_wr_en) mem_q[i_wr_addr] <= i_wr_data;
		o_rd_data <= mem_q[i_rd_addr]; // one cycle read latency
	end

endmodule

`default_nettype wire

// ==== verilog/scope_pkg.sv ====
// scope_pkg
// shared constants, opcodes and bundles for the acquisition core
`default_nettype none

package scope_pkg;

	localparam int          SAMPLE_W   = 12;     // adc sample width
	localparam logic [31:0] FW_VERSION = 32'd17; // answer to CMD_INFO

	// ----------------------------------------
	// opcodes and modes
	// ----------------------------------------
	typedef enum logic [7:0] {
		CMD_READ     = 8'd0,  // stream the buffer out
		CMD_ARM      = 8'd1,  // arm, report event status
		CMD_INFO     = 8'd2,  // firmware version
		CMD_TRIG_SET = 8'd8   // thresholds, preoffset, tot
	} cmd_op_e;

	typedef enum logic [7:0] {
		TRIG_NONE = 8'd0, // take data right away
		TRIG_FALL = 8'd1,
		TRIG_RISE = 8'd2
	} trig_type_e;

	typedef enum logic [2:0] {
		ACQ_IDLE,
		ACQ_FALL_ARM,  // waiting for a sample under lower
		ACQ_FALL_WAIT, // counting samples over upper
		ACQ_RISE_ARM,  // waiting for a sample over upper
		ACQ_RISE_WAIT, // counting samples under lower
		ACQ_POST,      // post-trigger capture
		ACQ_DONE       // event held for readout
	} acq_state_e;

	// ----------------------------------------
	// bundles
	// ----------------------------------------
	// byte 0 sits in the low bits, so byte k is bits [8k +: 8]
	typedef struct packed {
		logic [7:0] b7;
		logic [7:0] b6;
		logic [7:0] b5;
		logic [7:0] b4;
		logic [7:0] b3;
		logic [7:0] b2;
		logic [7:0] b1;
		cmd_op_e    op;
	} cmd_t;

	typedef struct packed {
		trig_type_e                 trig_type;
		logic signed [SAMPLE_W-1:0] lower;          // hysteresis low side
		logic signed [SAMPLE_W-1:0] upper;          // hysteresis high side
		logic [7:0]                 tot;            // time over threshold
		logic [15:0]                length_to_take; // post-trigger samples
	} trig_cfg_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  keep;
		logic        last;
	} resp_beat_t;

endpackage

`default_nettype wire

// ==== verilog/scope_top.sv ====
// scope_top
// command-driven acquisition core, byte stream in, 32-bit reply stream out
`timescale 1ns/1ps
`default_nettype none

module scope_top import scope_pkg::*; #(
	parameter int ADDR_W = 8 // 256-sample ring
) (
	input  wire                       clk,
	input  wire                       rstn,
	input  wire                       i_tvalid,
	input  wire  [7:0]                i_tdata,
	output logic                      o_tready,
	output logic                      o_tvalid,
	output logic [31:0]               o_tdata,
	output logic [3:0]                o_tkeep,
	output logic                      o_tlast,
	input  wire                       i_tready,
	input  wire signed [SAMPLE_W-1:0] i_sample,
	input  wire                       i_sample_valid
);

	// ----------------------------------------
	// interconnect
	// ----------------------------------------
	cmd_t                cmd;
	logic                cmd_valid;
	logic                cmd_done;
	trig_cfg_t           cfg;
	logic                arm;
	logic                readout_done;
	logic                wr_en;
	logic [ADDR_W-1:0]   wr_addr;
	logic [SAMPLE_W-1:0] wr_data;
	logic [ADDR_W-1:0]   trig_addr;
	logic [15:0]         event_count;
	logic [15:0]         post_count;
	logic [ADDR_W-1:0]   rd_addr;
	logic [SAMPLE_W-1:0] rd_data;
	resp_beat_t          beat;
	logic                beat_valid;
	logic                beat_ready;

	cmd_receiver u_cmd_receiver (
		.clk         (clk),
		.rstn        (rstn),
		.i_tvalid    (i_tvalid),
		.i_tdata     (i_tdata),
		.o_tready    (o_tready),
		.i_cmd_done  (cmd_done),
		.o_cmd       (cmd),
		.o_cmd_valid (cmd_valid)
	);

	acq_trigger #(.ADDR_W(ADDR_W)) u_acq_trigger (
		.clk            (clk),
		.rstn           (rstn),
		.i_sample       (i_sample),
		.i_sample_valid (i_sample_valid),
		.i_cfg          (cfg),
		.i_arm          (arm),
		.i_readout_done (readout_done),
		.o_wr_en        (wr_en),
		.o_wr_addr      (wr_addr),
		.o_wr_data      (wr_data),
		.o_trig_addr    (trig_addr),
		.o_event_count  (event_count),
		.o_post_count   (post_count)
	);

	sample_ram #(.ADDR_W(ADDR_W)) u_sample_ram (
		.clk       (clk),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	cmd_processor #(.ADDR_W(ADDR_W)) u_cmd_processor (
		.clk            (clk),
		.rstn           (rstn),
		.i_cmd          (cmd),
		.i_cmd_valid    (cmd_valid),
		.o_cmd_done     (cmd_done),
		.o_cfg          (cfg),
		.o_arm          (arm),
		.o_readout_done (readout_done),
		.i_trig_addr    (trig_addr),
		.i_event_count  (event_count),
		.i_post_count   (post_count),
		.o_rd_addr      (rd_addr),
		.i_rd_data      (rd_data),
		.o_beat         (beat),
		.o_beat_valid   (beat_valid),
		.i_beat_ready   (beat_ready)
	);

	resp_stream u_resp_stream (
		.clk          (clk),
		.rstn         (rstn),
		.i_beat       (beat),
		.i_beat_valid (beat_valid),
		.o_beat_ready (beat_ready),
		.o_tvalid     (o_tvalid),
		.o_tdata      (o_tdata),
		.o_tkeep      (o_tkeep),
		.o_tlast      (o_tlast),
		.i_tready     (i_tready)
	);

endmodule

`default_nettype wire
